//--- rtl/icache_geom_pkg.sv
`default_nettype none

package icache_geom_pkg;

    // fetch address
    parameter int ADDR_W = 32;

    // two instructions per fetch
    parameter int FETCH_W = 64;

    // one line = one memory beat
    parameter int LINE_W = 512;

    // 64-byte lines
    parameter int OFFSET_W = 6;

    typedef logic [ADDR_W-1:0]  addr_t;
    typedef logic [FETCH_W-1:0] fetch_t;
    typedef logic [LINE_W-1:0]  line_t;

endpackage

`default_nettype wire

//--- rtl/icache_state_pkg.sv
`default_nettype none

package icache_state_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE   = 2'd0,  // waiting for a fetch
        LOOKUP = 2'd1,  // tag compare, hit response
        MISS   = 2'd2,  // line request outstanding
        REFILL = 2'd3   // response from line buffer
    } ctrl_state_t;

    // way number, 0 or 1
    typedef logic way_t;

endpackage

`default_nettype wire

//--- rtl/sync_ram.sv
`default_nettype none

module sync_ram #(
    parameter type T          = logic,
    parameter int  ADDR_W_RAM = 6
) (
    input  wire logic                  clk,
    input  wire logic [ADDR_W_RAM-1:0] i_raddr,
    input  wire logic [ADDR_W_RAM-1:0] i_waddr,
    input  wire logic                  i_we,
    input  wire T                      i_wdata,
    output      T                      o_rdata
);

    localparam int DEPTH = 1 << ADDR_W_RAM;

    T mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;
        end
    end

    // registered read, old data on a same-index write
    always_ff @(posedge clk) begin
        o_rdata <= mem[i_raddr];
    end

endmodule

`default_nettype wire

//--- rtl/icache_ways.sv
`default_nettype none

module icache_ways
    import icache_geom_pkg::*;
    import icache_state_pkg::*;
#(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_W       = ADDR_W - OFFSET_W - INDEX_WIDTH
) (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic [INDEX_WIDTH-1:0] i_rindex,    // also the refill index
    input  wire logic [TAG_W-1:0]       i_tag,
    input  wire logic [2:0]             i_offset,    // pair within the line
    input  wire logic                   i_from_line,
    input  wire logic                   i_refill_we,
    input  wire way_t                   i_refill_way,
    input  wire logic                   i_mem_ready,
    input  wire line_t                  i_mem_data,
    output      logic                   o_hit,
    output      way_t                   o_hit_way,
    output      fetch_t                 o_rsp_data
);

    localparam int SETS = 1 << INDEX_WIDTH;

    typedef logic [TAG_W-1:0] tag_t;

    tag_t       tag_rd  [2];
    line_t      line_rd [2];
    logic [1:0] hit;

    line_t line_buf;  // last line from memory
    line_t line_sel;

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic            we;
        logic [SETS-1:0] valid;
        logic            valid_q;  // valid bit, aligned with the ram read

        assign we = i_refill_we && (i_refill_way == way_t'(w));

        sync_ram #(
            .T          (tag_t),
            .ADDR_W_RAM (INDEX_WIDTH)
        ) u_tag_ram (
            .clk     (clk),
            .i_raddr (i_rindex),
            .i_waddr (i_rindex),
            .i_we    (we),
            .i_wdata (i_tag),
            .o_rdata (tag_rd[w])
        );

        sync_ram #(
            .T          (line_t),
            .ADDR_W_RAM (INDEX_WIDTH)
        ) u_data_ram (
            .clk     (clk),
            .i_raddr (i_rindex),
            .i_waddr (i_rindex),
            .i_we    (we),
            .i_wdata (i_mem_data),  // line written straight from memory
            .o_rdata (line_rd[w])
        );

        always_ff @(posedge clk) begin
            if (!rstn) begin
                valid   <= '0;
                valid_q <= 1'b0;
            end else begin
                if (we) begin
                    valid[i_rindex] <= 1'b1;
                end
                valid_q <= valid[i_rindex];
            end
        end

        assign hit[w] = valid_q && (tag_rd[w] == i_tag);
    end

    always_ff @(posedge clk) begin
        if (i_mem_ready) begin
            line_buf <= i_mem_data;
        end
    end

    assign o_hit     = |hit;
    assign o_hit_way = hit[0] ? way_t'(0) : way_t'(1);  // way 0 wins a double hit

    always_comb begin
        if (i_from_line) begin
            line_sel = line_buf;
        end else begin
            line_sel = line_rd[o_hit_way];
        end
        o_rsp_data = line_sel[i_offset * FETCH_W +: FETCH_W];
    end

endmodule

`default_nettype wire

//--- rtl/icache_ctrl.sv
`default_nettype none

module icache_ctrl
    import icache_geom_pkg::*;
    import icache_state_pkg::*;
#(
    parameter  int INDEX_WIDTH = 6,
    localparam int TAG_W       = ADDR_W - OFFSET_W - INDEX_WIDTH
) (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    // fetch request
    input  wire logic                   i_req_valid,
    input  wire addr_t                  i_req_addr,
    output      logic                   o_req_ready,
    // fetch response
    input  wire logic                   i_rsp_ready,
    output      logic                   o_rsp_valid,
    // lookup result from the ways
    input  wire logic                   i_hit,
    input  wire way_t                   i_hit_way,
    // memory
    input  wire logic                   i_mem_ready,
    output      logic                   o_mem_valid,
    output      addr_t                  o_mem_addr,
    // to the ways
    output      logic [INDEX_WIDTH-1:0] o_rindex,
    output      logic [TAG_W-1:0]       o_tag,
    output      logic [2:0]             o_offset,
    output      logic                   o_from_line,
    output      logic                   o_refill_we,
    output      way_t                   o_refill_way
);

    localparam int SETS = 1 << INDEX_WIDTH;

    ctrl_state_t state;
    ctrl_state_t state_nxt;

    addr_t                  req_buf;
    logic [INDEX_WIDTH-1:0] buf_index;
    logic [SETS-1:0]        lru;  // per set, the way to replace next

    logic req_fire;
    logic hit_fire;

    assign buf_index = req_buf[OFFSET_W +: INDEX_WIDTH];

    assign req_fire = i_req_valid && o_req_ready;
    assign hit_fire = (state == LOOKUP) && i_hit && i_rsp_ready;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:    if (i_req_valid) state_nxt = LOOKUP;
            LOOKUP: begin
                if (!i_hit) begin
                    state_nxt = MISS;
                end else if (i_rsp_ready) begin
                    state_nxt = IDLE;
                end
            end
            MISS:    if (i_mem_ready) state_nxt = REFILL;
            REFILL:  if (i_rsp_ready) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    // request buffer
    always_ff @(posedge clk) begin
        if (req_fire) begin
            req_buf <= i_req_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru <= '0;
        end else if (hit_fire) begin
            lru[buf_index] <= ~i_hit_way;
        end else if (o_refill_we) begin
            lru[buf_index] <= ~lru[buf_index];  // refilled way becomes MRU
        end
    end

    assign o_req_ready = (state == IDLE);
    assign o_rsp_valid = ((state == LOOKUP) && i_hit) || (state == REFILL);

    assign o_mem_valid = (state == MISS);
    assign o_mem_addr  = {req_buf[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

    // request index while accepting, buffered index afterwards
    assign o_rindex     = (state == IDLE) ? i_req_addr[OFFSET_W +: INDEX_WIDTH] : buf_index;
    assign o_tag        = req_buf[ADDR_W-1 -: TAG_W];
    assign o_offset     = req_buf[5:3];
    assign o_from_line  = (state == REFILL);
    assign o_refill_we  = (state == MISS) && i_mem_ready;
    assign o_refill_way = way_t'(lru[buf_index]);

endmodule

`default_nettype wire

//--- rtl/icache_top.sv
`default_nettype none

module icache_top
    import icache_geom_pkg::*;
    import icache_state_pkg::*;
#(
    parameter int INDEX_WIDTH = 6
) (
    input  wire logic   clk,
    input  wire logic   rstn,
    // fetch request
    input  wire logic   i_req_valid,
    input  wire addr_t  i_req_addr,
    output      logic   o_req_ready,
    // fetch response
    output      logic   o_rsp_valid,
    output      fetch_t o_rsp_data,
    input  wire logic   i_rsp_ready,
    // memory, one full line per request
    output      logic   o_mem_valid,
    output      addr_t  o_mem_addr,
    input  wire logic   i_mem_ready,
    input  wire line_t  i_mem_data
);

    localparam int TAG_W = ADDR_W - OFFSET_W - INDEX_WIDTH;

    logic [INDEX_WIDTH-1:0] rindex;
    logic [TAG_W-1:0]       tag;
    logic [2:0]             offset;
    logic                   from_line;
    logic                   refill_we;
    way_t                   refill_way;
    logic                   hit;
    way_t                   hit_way;

    icache_ctrl #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ctrl (
        .clk          (clk),
        .rstn         (rstn),
        .i_req_valid  (i_req_valid),
        .i_req_addr   (i_req_addr),
        .o_req_ready  (o_req_ready),
        .i_rsp_ready  (i_rsp_ready),
        .o_rsp_valid  (o_rsp_valid),
        .i_hit        (hit),
        .i_hit_way    (hit_way),
        .i_mem_ready  (i_mem_ready),
        .o_mem_valid  (o_mem_valid),
        .o_mem_addr   (o_mem_addr),
        .o_rindex     (rindex),
        .o_tag        (tag),
        .o_offset     (offset),
        .o_from_line  (from_line),
        .o_refill_we  (refill_we),
        .o_refill_way (refill_way)
    );

    icache_ways #(
        .INDEX_WIDTH (INDEX_WIDTH)
    ) u_ways (
        .clk          (clk),
        .rstn         (rstn),
        .i_rindex     (rindex),
        .i_tag        (tag),
        .i_offset     (offset),
        .i_from_line  (from_line),
        .i_refill_we  (refill_we),
        .i_refill_way (refill_way),
        .i_mem_ready  (i_mem_ready),
        .i_mem_data   (i_mem_data),
        .o_hit        (hit),
        .o_hit_way    (hit_way),
        .o_rsp_data   (o_rsp_data)
    );

endmodule

`default_nettype wire

//--- tb/icache_checker.sv
`default_nettype none

module icache_checker
    import icache_geom_pkg::*;
(
    input wire logic   clk,
    input wire logic   rstn,
    input wire logic   i_req_ready,
    input wire logic   i_rsp_valid,
    input wire fetch_t i_rsp_data,
    input wire logic   i_rsp_ready,
    input wire logic   i_mem_valid,
    input wire addr_t  i_mem_addr,
    input wire logic   i_mem_ready
);
    timeunit 1ns;
    timeprecision 100ps;

    int err_count = 0;  // assertion failures so far

    // response held until accepted
    a_rsp_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_rsp_valid && !i_rsp_ready |=> i_rsp_valid && $stable(i_rsp_data))
    else begin
        $error("response dropped or changed before it was accepted");
        err_count++;
    end

    a_mem_hold: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_valid && !i_mem_ready |=> i_mem_valid && $stable(i_mem_addr))
    else begin
        $error("memory request dropped or changed before ready");
        err_count++;
    end

    a_mem_align: assert property (@(posedge clk) disable iff (!rstn)
        i_mem_valid |-> (i_mem_addr[5:0] == 6'd0))
    else begin
        $error("memory request address is not line aligned");
        err_count++;
    end

    // a new fetch never overlaps an open response
    a_req_rsp: assert property (@(posedge clk) disable iff (!rstn)
        !(i_req_ready && i_rsp_valid))
    else begin
        $error("request ready while a response is pending");
        err_count++;
    end

endmodule

bind icache_top icache_checker u_checker (
    .clk         (clk),
    .rstn        (rstn),
    .i_req_ready (o_req_ready),
    .i_rsp_valid (o_rsp_valid),
    .i_rsp_data  (o_rsp_data),
    .i_rsp_ready (i_rsp_ready),
    .i_mem_valid (o_mem_valid),
    .i_mem_addr  (o_mem_addr),
    .i_mem_ready (i_mem_ready)
);

`default_nettype wire

//--- tb/icache_tb.sv
`default_nettype none

module icache_tb
    import icache_geom_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int SEED            = 32'h1c23be55;
    localparam int CYCLES_PER_TEST = 40;

    logic   clk = 1'b0;
    logic   rstn;
    logic   i_req_valid;
    addr_t  i_req_addr;
    logic   o_req_ready;
    logic   o_rsp_valid;
    fetch_t o_rsp_data;
    logic   i_rsp_ready;
    logic   o_mem_valid;
    addr_t  o_mem_addr;
    logic   i_mem_ready;
    line_t  i_mem_data;

    string names[$];
    addr_t addrs[$];
    bit    exp_misses[$];

    int errors       = 0;
    int tests_failed = 0;
    int n_tests      = 0;
    bit loaded       = 1'b0;

    // handed from the fetch task to the memory model
    int    mem_delay = 0;
    int    mem_count = 0;
    addr_t exp_line;
    string cur_name;

    icache_top #(
        .INDEX_WIDTH (6)
    ) DUT (
        .clk         (clk),
        .rstn        (rstn),
        .i_req_valid (i_req_valid),
        .i_req_addr  (i_req_addr),
        .o_req_ready (o_req_ready),
        .o_rsp_valid (o_rsp_valid),
        .o_rsp_data  (o_rsp_data),
        .i_rsp_ready (i_rsp_ready),
        .o_mem_valid (o_mem_valid),
        .o_mem_addr  (o_mem_addr),
        .i_mem_ready (i_mem_ready),
        .i_mem_data  (i_mem_data)
    );

    always #5 clk = ~clk;

    // every memory word holds its own byte address
    function automatic line_t make_line(input addr_t base);
        line_t line;
        for (int k = 0; k < LINE_W / 32; k++) begin
            line[32*k +: 32] = base + 32'(4 * k);
        end
        return line;
    endfunction

    function automatic fetch_t expected_pair(input addr_t addr);
        addr_t a8;
        a8 = {addr[ADDR_W-1:3], 3'b000};
        return {a8 + 32'd4, a8};
    endfunction

    always begin : memory_model
        @(negedge clk);
        if (o_mem_valid) begin
            repeat (mem_delay) @(negedge clk);
            assert (o_mem_addr == exp_line) else begin
                $display("FAIL %s: memory address expected %h, got %h",
                         cur_name, exp_line, o_mem_addr);
                errors++;
            end
            i_mem_data  = make_line(o_mem_addr);
            i_mem_ready = 1'b1;
            mem_count++;
            @(negedge clk);
            i_mem_ready = 1'b0;  // line taken on the last rising edge
        end
    end

    task automatic run_fetch(input string name, input addr_t addr, input bit exp_miss);
        fetch_t exp_data;
        fetch_t got;
        int     stall;
        int     count_before;
        int     errors_before;
        exp_data      = expected_pair(addr);
        stall         = $urandom_range(3, 0);  // response cycles held back
        mem_delay     = $urandom_range(7, 0);
        errors_before = errors;
        count_before  = mem_count;
        cur_name      = name;
        exp_line      = addr & 32'hffff_ffc0;  // 64-byte line base
        while (!o_req_ready) @(negedge clk);
        i_req_valid = 1'b1;
        i_req_addr  = addr;
        i_rsp_ready = (stall == 0);
        @(negedge clk);
        i_req_valid = 1'b0;
        if (!exp_miss) begin
            assert (o_rsp_valid) else begin
                $display("%s: hit response missing one cycle after the request", name);
                errors++;
            end
        end
        while (!(o_rsp_valid && i_rsp_ready)) begin
            if (o_rsp_valid) begin
                stall--;  // one more cycle held back
            end
            @(negedge clk);
            i_rsp_ready = (stall == 0);
        end
        got = o_rsp_data;
        @(negedge clk);  // accepted on the edge in between
        assert (got == exp_data) else begin
            $display("FAIL %s: data expected %h, got %h", name, exp_data, got);
            errors++;
        end
        assert ((mem_count - count_before) == int'(exp_miss)) else begin
            $display("FAIL %s: memory requests expected %0d, got %0d",
                     name, int'(exp_miss), mem_count - count_before);
            errors++;
        end
        if (errors != errors_before) tests_failed++;
        $display("test %s: %s (%s)", name, (errors == errors_before) ? "ok" : "failed",
                 exp_miss ? "miss" : "hit");
    endtask

    initial begin : main
        int    fd;
        int    c;
        int    n;
        int    miss;
        string tok;
        addr_t addr;
        void'($urandom(SEED));
        rstn        = 1'b0;
        i_req_valid = 1'b0;
        i_req_addr  = '0;
        i_rsp_ready = 1'b1;
        i_mem_ready = 1'b0;
        i_mem_data  = '0;
        fd = $fopen("tb/icache_input.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file tb/icache_input.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", tok) == 1) begin
                if (tok[0] == "#") begin
                    do begin
                        c = $fgetc(fd);
                    end while (c != "\n" && c != -1);
                end else begin
                    n = $fscanf(fd, "%h %d", addr, miss);
                    if (n != 2) begin
                        $display("stimulus line for %s is malformed", tok);
                        errors++;
                    end else begin
                        names.push_back(tok);
                        addrs.push_back(addr);
                        exp_misses.push_back(miss != 0);
                    end
                end
            end
            $fclose(fd);
        end
        n_tests = names.size();
        loaded  = 1'b1;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < n_tests; i++) begin
            run_fetch(names[i], addrs[i], exp_misses[i]);
        end
        errors += DUT.u_checker.err_count;
        $display("tests run: %0d, failed: %0d, checker errors: %0d",
                 n_tests, tests_failed, DUT.u_checker.err_count);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_tests * CYCLES_PER_TEST + 20) @(posedge clk);
        $display("timeout: run still busy after %0d cycles", n_tests * CYCLES_PER_TEST + 20);
        $display("Done: errors found");
        $finish;
    end

endmodule

`default_nettype wire

//--- flist.f
rtl/icache_geom_pkg.sv
rtl/icache_state_pkg.sv
rtl/sync_ram.sv
rtl/icache_ways.sv
rtl/icache_ctrl.sv
rtl/icache_top.sv
tb/icache_checker.sv
tb/icache_tb.sv

//--- tb/icache_input.txt
# columns: test name, fetch address (hex), expected miss (1 = line fetched from memory)
# tags 0x1, 0x2, 0x3 share set 1; LRU bits start at way 0
cold_miss     00001048  1
same_line     00001070  0
second_tag    00002044  1
alt_a         00001040  0
alt_b         00002078  0
alt_a2        0000105c  0
third_tag     00003040  1
old_a         00001048  0
evicted_b     00002040  1
third_again   00003050  1
b_again       00002060  0
a_again       00001040  1
set0_cold     00000000  1
set0_hit      00000038  0
set63_cold    00000fc0  1
set63_hit     00000ff8  0
high_addr     fffff004  1
set0_both     00000008  0
high_hit      fffff03c  0
